/* decode_cases.txt */
# L word_addr instr | R reg value | E pc alu_op imm alu_op1 alu_op2 flags rd
# flags bits 7..0 are branch jal jalr mem_read mem_write reg_write alu_src1 alu_src2
L 00 ffd08293
L 01 40218333
L 02 fe312c23
L 03 00c0a383
L 04 fe2088e3
L 05 80001437
L 06 00012497
L 07 001000ef
L 08 fff182e7
L 09 00118a23
L 0a 00019463
L 0b ffdff06f
L 0c 40305533
L 0d 00000fff
R 01 00000010
R 02 fffffff0
R 03 12345678
R 00 deadbeef
E 00 0 fffffffd 00000010 fffffffd 05 05
E 04 1 00000000 12345678 fffffff0 04 06
E 08 0 fffffff8 fffffff0 fffffff8 09 00
E 0c 0 0000000c 00000010 0000000c 15 07
E 10 0 fffffff0 00000010 fffffff0 83 00
E 14 a 80001000 00000000 80001000 05 08
E 18 0 00012000 00000018 00012000 07 09
E 1c 0 00000800 0000001c 00000800 47 01
E 20 0 ffffffff 12345678 ffffffff 25 05
E 24 0 00000014 12345678 00000014 09 00
E 28 0 00000008 00000028 00000008 83 00
E 2c 0 fffffffc 0000002c fffffffc 47 00
E 30 7 00000000 00000000 12345678 04 0a
E 34 0 00000000 00000000 00000000 00 00

/* rv_decode.f */
rv_decode_pkg.sv
fetch_unit.sv
instr_mem.sv
imm_gen.sv
control_unit.sv
alu_control.sv
regfile.sv
decode_top.sv
tb_decode_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode front-end testbench with Verilator.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_top -f rv_decode.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_decode_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* tb_decode_top.sv */
module tb_decode_top;
    import rv_decode_pkg::*;

    typedef struct packed {
        logic [imem_aw-1:0] addr;
        logic [xlen-1:0]    data;
    } load_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [3:0]      alu_op;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic [7:0]      flags;
        logic [4:0]      rd;
    } expect_t;

    localparam int hold_window = 12; // cycles after run rises with every credit kept.
    localparam int wait_limit  = 200;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               load_en;
    logic [imem_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               run;
    rf_write_t          wb;
    logic               credit_return;
    logic               out_valid;
    decoded_t           out;

    load_t           loads[$];
    rf_write_t       presets[$];
    expect_t         expects[$];
    logic [xlen-1:0] prog [imem_words]; // copy of the loaded program, indexed by word.
    logic [xlen-1:0] reg_model [32];
    bit              reg_known [32]; // registers whose contents the presets define.
    integer          seed = 32'h49f6_fda0;

    always #20 clk = ~clk;

    decode_top i_decode_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .run           (run),
        .wb            (wb),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out           (out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run;
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic read_cases;
        int          fd;
        int          n;
        string       line;
        string       rest;
        logic [31:0] v0, v1, v2, v3, v4, v5, v6;
        load_t       l;
        rf_write_t   p;
        expect_t     e;
        reg_model[0] = '0;
        reg_known[0] = 1'b1; // x0 always reads as zero.
        fd = $fopen("decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open decode_cases.txt");
            stop_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    rest = line.substr(1, line.len() - 1);
                    case (line.getc(0))
                        "L":     n = $sscanf(rest, " %h %h", v0, v1) - 2;
                        "R":     n = $sscanf(rest, " %h %h", v0, v1) - 2;
                        "E":     n = $sscanf(rest, " %h %h %h %h %h %h %h",
                                             v0, v1, v2, v3, v4, v5, v6) - 7;
                        default: n = -1;
                    endcase
                    if (n != 0) begin
                        $display("unreadable line in decode_cases.txt: %s", line);
                        stop_run();
                    end else if (line.getc(0) == "L") begin
                        l.addr = v0[imem_aw-1:0];
                        l.data = v1;
                        loads.push_back(l);
                        prog[l.addr] = l.data;
                    end else if (line.getc(0) == "R") begin
                        p.en   = 1'b1;
                        p.addr = v0[4:0];
                        p.data = v1;
                        presets.push_back(p);
                        if (p.addr != 5'd0) begin
                            reg_model[p.addr] = p.data;
                            reg_known[p.addr] = 1'b1;
                        end
                    end else begin
                        e.pc     = v0;
                        e.alu_op = v1[3:0];
                        e.imm    = v2;
                        e.op1    = v3;
                        e.op2    = v4;
                        e.flags  = v5[7:0];
                        e.rd     = v6[4:0];
                        expects.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_bundle(input expect_t e);
        logic [7:0]      flags;
        logic [xlen-1:0] word;
        logic [6:0]      opcode;
        flags = {out.ctrl.branch, out.ctrl.jal, out.ctrl.jalr, out.ctrl.mem_read,
                 out.ctrl.mem_write, out.ctrl.reg_write, out.ctrl.alu_src1, out.ctrl.alu_src2};
        word   = prog[e.pc[imem_aw+1:2]];
        opcode = (e.flags == 8'h00) ? op_illegal : word[6:0]; // only an illegal word sets no flag.
        check_val("out.pc", out.pc, e.pc);
        check_val("out.instr", out.instr, word);
        check_val("out.ctrl.opcode", 32'(out.ctrl.opcode), 32'(opcode));
        check_val("out.ctrl.rs1", 32'(out.ctrl.rs1), 32'(word[19:15]));
        check_val("out.ctrl.rs2", 32'(out.ctrl.rs2), 32'(word[24:20]));
        if (reg_known[word[19:15]]) begin
            check_val("out.rs1_data", out.rs1_data, reg_model[word[19:15]]);
        end
        if (reg_known[word[24:20]]) begin
            check_val("out.rs2_data", out.rs2_data, reg_model[word[24:20]]);
        end
        check_val("out.alu_op", 32'(out.alu_op), 32'(e.alu_op));
        check_val("out.imm", out.imm, e.imm);
        check_val("out.alu_op1", out.alu_op1, e.op1);
        check_val("out.alu_op2", out.alu_op2, e.op2);
        check_val("out.ctrl flags", 32'(flags), 32'(e.flags));
        check_val("out.ctrl.rd", 32'(out.ctrl.rd), 32'(e.rd));
    endtask

    task automatic quiet_cycle;
        @(negedge clk);
        check_val("out_valid", 32'(out_valid), 32'd0); // nothing may issue while run is low.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int seen;
        int held;
        int idle;
        int cycle;
        int coin;
        seen          = 0;
        held          = 0;
        idle          = 0;
        cycle         = 0;
        rst_n         = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        run           = 1'b0;
        wb            = '0;
        credit_return = 1'b0;
        read_cases();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        quiet_cycle();
        foreach (loads[i]) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= loads[i].addr;
            load_data <= loads[i].data;
            quiet_cycle();
        end
        foreach (presets[i]) begin
            @(posedge clk);
            load_en <= 1'b0;
            wb      <= presets[i];
            quiet_cycle();
        end
        @(posedge clk);
        load_en <= 1'b0;
        wb      <= '0;
        repeat (4) quiet_cycle();
        @(posedge clk);
        run <= 1'b1;

        // held counts bundles seen and not yet handed back, so a return is always owed.
        while (seen < expects.size()) begin
            @(posedge clk);
            credit_return <= 1'b0;
            if (cycle >= hold_window) begin
                coin = $random(seed);
                if (held > 0 && coin[0]) begin
                    credit_return <= 1'b1;
                    held--;
                end
            end
            @(negedge clk);
            cycle++;
            if (out_valid) begin
                compare_bundle(expects[seen]);
                seen++;
                held++;
                idle = 0;
            end else if (idle == wait_limit) begin
                $display("timed out waiting for out_valid after %0d bundles", seen);
                stop_run();
            end else begin
                idle++;
            end
            if (cycle == hold_window) begin
                check_val("bundles with credits withheld", seen, dec_credits);
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* decode_top.sv */
module decode_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_en,
    input  logic [rv_decode_pkg::imem_aw-1:0] load_addr,
    input  logic [rv_decode_pkg::xlen-1:0]    load_data,
    input  logic                              run,
    input  rv_decode_pkg::rf_write_t          wb,
    input  logic                              credit_return,
    output logic                              out_valid,
    output rv_decode_pkg::decoded_t           out
);
    import rv_decode_pkg::*;

    logic [imem_aw-1:0] imem_addr;
    logic               fetch_fire;
    logic [xlen-1:0]    fetch_pc;
    logic [xlen-1:0]    instr;
    logic [xlen-1:0]    imm;
    logic [xlen-1:0]    rs1_data;
    logic [xlen-1:0]    rs2_data;
    logic [xlen-1:0]    alu_op1;
    logic [xlen-1:0]    alu_op2;
    ctrl_t              ctrl;
    alu_op_e            alu_op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .credit_return (credit_return),
        .imem_addr     (imem_addr),
        .fetch_fire    (fetch_fire),
        .fetch_pc      (fetch_pc),
        .issued        (out_valid)
    );

    instr_mem i_instr_mem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (fetch_fire),
        .rd_addr   (imem_addr),
        .instr     (instr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    control_unit i_control_unit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1_addr (ctrl.rs1),
        .rs2_addr (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_control i_alu_control (
        .instr    (instr),
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (fetch_pc),
        .alu_op   (alu_op),
        .alu_op1  (alu_op1),
        .alu_op2  (alu_op2)
    );

    assign out.pc       = fetch_pc;
    assign out.instr    = instr;
    assign out.ctrl     = ctrl;
    assign out.imm      = imm;
    assign out.rs1_data = rs1_data;
    assign out.rs2_data = rs2_data;
    assign out.alu_op   = alu_op;
    assign out.alu_op1  = alu_op1;
    assign out.alu_op2  = alu_op2;

endmodule

/* regfile.sv */
module regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv_decode_pkg::rf_write_t       wb,
    input  logic [4:0]                     rs1_addr,
    input  logic [4:0]                     rs2_addr,
    output logic [rv_decode_pkg::xlen-1:0] rs1_data,
    output logic [rv_decode_pkg::xlen-1:0] rs2_data
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] regs [32];

    // entry 0 is never written and is masked on read.
    always_ff @(posedge clk) begin
        if (rst_n && wb.en && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // the writeback port is driven from outside the core.
    a_wb_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb.en |-> !$isunknown(wb.addr));

endmodule

/* alu_control.sv */
module alu_control (
    input  logic [rv_decode_pkg::xlen-1:0] instr,
    input  rv_decode_pkg::ctrl_t           ctrl,
    input  logic [rv_decode_pkg::xlen-1:0] rs1_data,
    input  logic [rv_decode_pkg::xlen-1:0] rs2_data,
    input  logic [rv_decode_pkg::xlen-1:0] imm,
    input  logic [rv_decode_pkg::xlen-1:0] pc,
    output rv_decode_pkg::alu_op_e         alu_op,
    output logic [rv_decode_pkg::xlen-1:0] alu_op1,
    output logic [rv_decode_pkg::xlen-1:0] alu_op2
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic       funct7_5;

    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    always_comb begin
        alu_op = alu_add; // address and target arithmetic all use add.
        if (ctrl.opcode == op_lui) begin
            alu_op = alu_pass_b;
        end else if (ctrl.opcode == op_imm || ctrl.opcode == op_reg) begin
            case (funct3)
                3'b000:  alu_op = (ctrl.opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl; // bit 30 marks srai too.
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    assign alu_op1 = ctrl.alu_src1 ? pc : rs1_data;
    assign alu_op2 = ctrl.alu_src2 ? imm : rs2_data;

endmodule

/* control_unit.sv */
module control_unit (
    input  logic [rv_decode_pkg::xlen-1:0] instr,
    output rv_decode_pkg::ctrl_t           ctrl
);
    import rv_decode_pkg::*;

    opcode_e op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (instr[6:0])
            op_lui:    op = op_lui;
            op_auipc:  op = op_auipc;
            op_jal:    op = op_jal;
            op_jalr:   op = op_jalr;
            op_branch: op = op_branch;
            op_load:   op = op_load;
            op_store:  op = op_store;
            op_imm:    op = op_imm;
            op_reg:    op = op_reg;
            default:   op = op_illegal;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fields and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ctrl        = '0;
        ctrl.opcode = op;
        ctrl.rs1    = instr[19:15];
        ctrl.rs2    = instr[24:20];
        ctrl.rd     = instr[11:7];
        case (op)
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src1  = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_jal: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src1  = 1'b1; // target is pc plus offset.
                ctrl.alu_src2  = 1'b1;
            end
            op_jalr: begin
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_branch: begin
                ctrl.branch   = 1'b1;
                ctrl.alu_src1 = 1'b1;
                ctrl.alu_src2 = 1'b1;
            end
            op_load: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src2  = 1'b1;
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
        if (!ctrl.reg_write) begin
            ctrl.rd = '0; // branches, stores and illegal words name no destination.
        end
    end

endmodule

/* imm_gen.sv */
module imm_gen (
    input  logic [rv_decode_pkg::xlen-1:0] instr,
    output logic [rv_decode_pkg::xlen-1:0] imm
);
    import rv_decode_pkg::*;

    logic sign;

    assign sign = instr[31]; // every format takes its sign from bit 31.

    always_comb begin
        case (instr[6:0])
            op_imm, op_load, op_jalr: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            op_store: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                imm = {instr[31:12], 12'b0};
            end
            op_jal: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // r-type and illegal words carry no immediate.
            end
        endcase
    end

endmodule

/* instr_mem.sv */
module instr_mem (
    input  logic                              clk,
    input  logic                              load_en,
    input  logic [rv_decode_pkg::imem_aw-1:0] load_addr,
    input  logic [rv_decode_pkg::xlen-1:0]    load_data,
    input  logic                              rd_en,
    input  logic [rv_decode_pkg::imem_aw-1:0] rd_addr,
    output logic [rv_decode_pkg::xlen-1:0]    instr
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] mem [imem_words];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // read data is held between fetches.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (load_en && (load_addr == rd_addr)) begin
                instr <= load_data; // the new word wins over the stored one.
            end else begin
                instr <= mem[rd_addr];
            end
        end
    end

endmodule

/* fetch_unit.sv */
module fetch_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              credit_return,
    output logic [rv_decode_pkg::imem_aw-1:0] imem_addr,
    output logic                              fetch_fire,
    output logic [rv_decode_pkg::xlen-1:0]    fetch_pc,
    output logic                              issued
);
    import rv_decode_pkg::*;

    logic [xlen-1:0]     pc;
    logic [credit_w-1:0] credits;

    // a credit coming back this cycle can be spent at once.
    assign fetch_fire = run && ((credits != '0) || credit_return);
    assign imem_addr  = pc[imem_aw+1:2]; // the memory is word addressed.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            credits <= credit_w'(dec_credits);
            issued  <= 1'b0;
        end else begin
            issued <= fetch_fire;
            if (fetch_fire) begin
                pc <= pc + xlen'(4);
            end
            if (fetch_fire && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!fetch_fire && credit_return) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            fetch_pc <= pc; // travels beside the word read from memory.
        end
    end

    // an underflow wraps to 3, so this bound also catches a negative count.
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= credit_w'(dec_credits));
    a_no_extra_return: assert property (@(posedge clk) disable iff (!rst_n)
        (credit_return && credits == credit_w'(dec_credits)) |-> fetch_fire);

endmodule

/* rv_decode_pkg.sv */
package rv_decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen        = 32;
    localparam int imem_words  = 64;
    localparam int imem_aw     = 6;
    localparam int dec_credits = 2; // matches the depth of the execute-side buffer.
    localparam int credit_w    = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_imm     = 7'b0010011,
        op_reg     = 7'b0110011,
        op_illegal = 7'b0000000 // no RV32I major opcode uses this value.
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10 // forwards operand b unchanged, for lui.
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       alu_src1; // operand a is the pc.
        logic       alu_src2; // operand b is the immediate.
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        ctrl_t           ctrl;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        alu_op_e         alu_op;
        logic [xlen-1:0] alu_op1;
        logic [xlen-1:0] alu_op2;
    } decoded_t;

    typedef struct packed {
        logic            en;
        logic [4:0]      addr;
        logic [xlen-1:0] data;
    } rf_write_t;

endpackage
